// ==== cartridge_top.f ====
logic/cartridge_pkg.sv
logic/slot_input_sync.sv
logic/msx_slot.sv
logic/test_controller.sv
logic/cartridge_top.sv
+incdir+testbench
testbench/tb_cartridge_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_cartridge_top
FILELIST  = cartridge_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

SOURCES = $(wildcard logic/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/msx_host_tasks.svh ====
/*
 * MSX host CPU model
 * slot I/O read and write cycles as driven from the CPU side
 */
`ifndef MSX_HOST_TASKS_SVH
`define MSX_HOST_TASKS_SVH

// step to just past the next rising edge
task automatic next_cycle();
	@(posedge clk42m);
	#1;
endtask

// ------------------------------------------------------------
// I/O write, strobes held for a fixed time
// ------------------------------------------------------------
task automatic io_write(input io_addr_t addr, input bus_data_t data);
	next_cycle();
	p_slot_address = {8'($urandom), addr};	// upper byte is don't care on I/O
	p_slot_wdata   = data;
	p_slot_ioreq_n = 1'b0;
	next_cycle();
	p_slot_wr_n = 1'b0;
	repeat (write_hold) next_cycle();
	p_slot_wr_n    = 1'b1;
	p_slot_ioreq_n = 1'b1;
	repeat (host_gap) next_cycle();		// host minimum between cycles
endtask

// ------------------------------------------------------------
// I/O read, stretched by the cartridge wait line
// ------------------------------------------------------------
task automatic io_read(input io_addr_t addr, output bus_data_t data,
		output logic dir, output logic dir_any);
	dir_any = 1'b0;
	next_cycle();
	p_slot_address = {8'($urandom), addr};
	p_slot_ioreq_n = 1'b0;
	next_cycle();
	p_slot_rd_n = 1'b0;
	do begin								// wait rises after the sync delay
		next_cycle();
		dir_any = dir_any | p_slot_data_dir;
	end while (!p_slot_wait);
	while (p_slot_wait) begin				// released once data is latched
		next_cycle();
		dir_any = dir_any | p_slot_data_dir;
	end
	data = p_slot_rdata;
	dir  = p_slot_data_dir;
	p_slot_rd_n    = 1'b1;
	p_slot_ioreq_n = 1'b1;
	repeat (host_gap) begin
		next_cycle();
		dir_any = dir_any | p_slot_data_dir;	// bus must stay quiet if unclaimed
	end
endtask

`endif

// ==== testbench/tb_cartridge_top.sv ====
/*
 * cartridge top level testbench
 * host model runs I/O cycles on the slot, reads checked against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cartridge_top import cartridge_pkg::*; ();

	localparam io_addr_t io_base      = 8'h10;
	localparam io_addr_t port_dipsw   = io_base;
	localparam io_addr_t port_scratch = io_base + 8'd1;
	localparam io_addr_t port_irq     = io_base + 8'd2;
	localparam int       seed         = 32'h0b88faa7;
	localparam int       cycle_limit  = 3000;	// 40 host cycles x 40 clocks, plus margin
	localparam int       write_hold   = 8;		// write strobe length in clocks
	localparam int       host_gap     = 4;		// idle clocks after each cycle

	typedef struct packed {
		logic      drive;					// cartridge should drive the bus
		bus_data_t data;
	} read_exp_t;

	logic        clk42m = 1'b0;
	logic        rst;
	dipsw_t      dipsw;
	logic        p_slot_ioreq_n;
	logic        p_slot_rd_n;
	logic        p_slot_wr_n;
	logic [15:0] p_slot_address;
	bus_data_t   p_slot_wdata;
	bus_data_t   p_slot_rdata;
	logic        p_slot_data_dir;
	logic        p_slot_wait;
	logic        p_slot_int;

	bus_data_t model_scratch;				// reference register state
	logic      model_irq;
	io_addr_t  addr;
	int        cycle_count = 0;
	int        error_count = 0;
	int        errors_at_start;
	int        tests_passed = 0;
	int        tests_failed = 0;

	cartridge_top #(
		.io_base ( io_base )
	) dut_i (
		.clk42m          ( clk42m          ),
		.rst             ( rst             ),
		.dipsw           ( dipsw           ),
		.p_slot_ioreq_n  ( p_slot_ioreq_n  ),
		.p_slot_rd_n     ( p_slot_rd_n     ),
		.p_slot_wr_n     ( p_slot_wr_n     ),
		.p_slot_address  ( p_slot_address  ),
		.p_slot_wdata    ( p_slot_wdata    ),
		.p_slot_rdata    ( p_slot_rdata    ),
		.p_slot_data_dir ( p_slot_data_dir ),
		.p_slot_wait     ( p_slot_wait     ),
		.p_slot_int      ( p_slot_int      )
	);

	always #2 clk42m = ~clk42m;				// 4 ns period

	`include "msx_host_tasks.svh"

	// ------------------------------------------------------------
	// reference model and compare
	// ------------------------------------------------------------
	function automatic read_exp_t expected_read(input io_addr_t a, input bus_data_t scratch,
			input logic irq_flag, input dipsw_t dip);
		read_exp_t exp;
		exp.drive = 1'b1;
		if (a == port_dipsw) begin
			exp.data = {3'b000, dip};		// switches zero-extended
		end else if (a == port_scratch) begin
			exp.data = scratch;
		end else if (a == port_irq) begin
			exp.data = {7'b0000000, irq_flag};
		end else begin
			exp.drive = 1'b0;				// nobody claims it
			exp.data  = 8'h00;
		end
		return exp;
	endfunction

	function automatic void report_value(input string name, input bus_data_t exp,
			input bus_data_t got);
		$display("FAIL %s expected %h got %h", name, exp, got);
		error_count++;
	endfunction

	task automatic write_port(input io_addr_t a, input bus_data_t data);
		io_write(a, data);
		if (a == port_scratch) model_scratch = data;
		if (a == port_irq) model_irq = data[0];
	endtask

	task automatic read_port(input io_addr_t a);
		bus_data_t data;
		logic      dir;
		logic      dir_any;
		read_exp_t exp;
		exp = expected_read(a, model_scratch, model_irq, dipsw);
		io_read(a, data, dir, dir_any);
		assert (dir == exp.drive)
			else report_value("p_slot_data_dir", bus_data_t'(exp.drive), bus_data_t'(dir));
		if (exp.drive) begin
			assert (data == exp.data) else report_value("p_slot_rdata", exp.data, data);
		end else begin
			assert (!dir_any) else report_value("p_slot_data_dir", 8'h00, 8'h01);
		end
	endtask

	task automatic finish_test(input string name);
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	// ------------------------------------------------------------
	// run limit
	// ------------------------------------------------------------
	always @(posedge clk42m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run stopped, no result after %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(seed));
		rst            = 1'b1;
		dipsw          = '0;
		p_slot_ioreq_n = 1'b1;				// host idle
		p_slot_rd_n    = 1'b1;
		p_slot_wr_n    = 1'b1;
		p_slot_address = '0;
		p_slot_wdata   = '0;
		model_scratch  = '0;
		model_irq      = 1'b0;
		errors_at_start = 0;
		repeat (3) next_cycle();
		rst = 1'b0;

		assert (!p_slot_wait) else report_value("p_slot_wait", 8'h00, 8'h01);
		assert (!p_slot_data_dir) else report_value("p_slot_data_dir", 8'h00, 8'h01);
		assert (!p_slot_int) else report_value("p_slot_int", 8'h00, 8'h01);
		finish_test("reset state");

		repeat (4) begin
			dipsw = dipsw_t'($urandom);
			read_port(port_dipsw);
		end
		finish_test("dip switch read");

		repeat (4) begin
			write_port(port_scratch, 8'($urandom));
			read_port(port_scratch);
		end
		write_port(port_dipsw, 8'($urandom));	// read-only port
		read_port(port_dipsw);
		finish_test("scratch register");

		write_port(port_irq, 8'h01);
		assert (p_slot_int) else report_value("p_slot_int", 8'h01, 8'h00);
		read_port(port_irq);
		write_port(port_irq, 8'h00);
		assert (!p_slot_int) else report_value("p_slot_int", 8'h00, 8'h01);
		read_port(port_irq);
		finish_test("interrupt");

		repeat (2) begin
			do begin
				addr = io_addr_t'($urandom);
			end while (addr >= port_dipsw && addr <= port_irq);
			read_port(addr);
		end
		finish_test("unclaimed address");

		repeat (20) begin
			addr = port_dipsw + io_addr_t'($urandom_range(0, 2));
			if ($urandom_range(0, 1) == 1) begin
				write_port(addr, 8'($urandom));
			end else begin
				read_port(addr);
			end
		end
		finish_test("back-to-back traffic");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/cartridge_top.sv ====
/*
 * cartridge top level
 * slot bridge wired to the I/O test controller over the cartridge bus
 */
`timescale 1ns/1ps
`default_nettype none

module cartridge_top import cartridge_pkg::*; #(
	parameter io_addr_t io_base = 8'h10		// controller port base
) (
	input  wire         clk42m,				// 42.95 MHz
	input  wire         rst,
	input  wire         dipsw_t dipsw,
	// MSX slot
	input  wire         p_slot_ioreq_n,
	input  wire         p_slot_rd_n,
	input  wire         p_slot_wr_n,
	input  wire  [15:0] p_slot_address,
	input  wire         bus_data_t p_slot_wdata,	// host -> cartridge
	output bus_data_t   p_slot_rdata,		// cartridge -> host
	output logic        p_slot_data_dir,	// drive enable for rdata
	output logic        p_slot_wait,
	output logic        p_slot_int
);

	// ------------------------------------------------------------
	// cartridge bus
	// ------------------------------------------------------------
	bus_req_t bus_req;
	logic     bus_valid;
	logic     bus_ready;
	bus_rsp_t bus_rsp;
	logic     irq;							// controller -> slot interrupt

	msx_slot u_msx_slot (
		.clk42m          ( clk42m          ),
		.rst             ( rst             ),
		.p_slot_ioreq_n  ( p_slot_ioreq_n  ),
		.p_slot_rd_n     ( p_slot_rd_n     ),
		.p_slot_wr_n     ( p_slot_wr_n     ),
		.p_slot_address  ( p_slot_address  ),
		.p_slot_wdata    ( p_slot_wdata    ),
		.p_slot_rdata    ( p_slot_rdata    ),
		.p_slot_data_dir ( p_slot_data_dir ),
		.p_slot_wait     ( p_slot_wait     ),
		.p_slot_int      ( p_slot_int      ),
		.irq             ( irq             ),
		.bus_req         ( bus_req         ),
		.bus_valid       ( bus_valid       ),
		.bus_ready       ( bus_ready       ),
		.bus_rsp         ( bus_rsp         )
	);

	test_controller #(
		.io_base ( io_base )
	) u_test_controller (
		.clk42m    ( clk42m    ),
		.rst       ( rst       ),
		.bus_req   ( bus_req   ),
		.bus_valid ( bus_valid ),
		.bus_ready ( bus_ready ),
		.bus_rsp   ( bus_rsp   ),
		.dipsw     ( dipsw     ),
		.irq       ( irq       )
	);

endmodule

`default_nettype wire

// ==== logic/test_controller.sv ====
/*
 * I/O test controller
 * three ports at io_base: DIP switch read, scratch register and
 * interrupt control, answered over the internal cartridge bus
 */
`timescale 1ns/1ps
`default_nettype none

module test_controller import cartridge_pkg::*; #(
	parameter io_addr_t io_base = 8'h10		// first of three ports
) (
	input  wire       clk42m,
	input  wire       rst,
	// internal bus
	input  wire       bus_req_t bus_req,
	input  wire       bus_valid,
	output logic      bus_ready,
	output bus_rsp_t  bus_rsp,
	// board
	input  wire       dipsw_t dipsw,
	output logic      irq					// 1: interrupt pending
);

	// port offsets from io_base
	localparam io_addr_t off_dipsw   = io_addr_t'(0);
	localparam io_addr_t off_scratch = io_addr_t'(1);
	localparam io_addr_t off_irq     = io_addr_t'(2);

	io_addr_t  offset;						// address relative to base
	logic      hit_dipsw;
	logic      hit_scratch;
	logic      hit_irq;
	logic      port_hit;					// any of our ports
	logic      accept;						// request transfers
	logic      rd_accept;					// read transfers
	bus_data_t read_mux;
	bus_data_t scratch_q;
	logic      done_q;						// response pending this cycle
	logic      claim_q;
	bus_data_t rdata_q;

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------
	assign offset      = bus_req.address - io_base;	// wraps at 8 bits
	assign hit_dipsw   = (offset == off_dipsw);
	assign hit_scratch = (offset == off_scratch);
	assign hit_irq     = (offset == off_irq);
	assign port_hit    = hit_dipsw | hit_scratch | hit_irq;

	assign bus_ready = ~done_q;				// busy only while responding
	assign accept    = bus_valid & bus_ready;
	assign rd_accept = accept & ~bus_req.write;

	always_comb begin
		read_mux = '0;						// unclaimed reads return 0
		if (hit_dipsw) begin
			read_mux = bus_data_t'(dipsw);	// zero-extended
		end else if (hit_scratch) begin
			read_mux = scratch_q;
		end else if (hit_irq) begin
			read_mux = {{(data_w-1){1'b0}}, irq};	// flag in bit 0
		end
	end

	// ------------------------------------------------------------
	// registers and response
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (rst) begin
			scratch_q <= '0;
			irq       <= 1'b0;
			done_q    <= 1'b0;
			claim_q   <= 1'b0;
		end else begin
			done_q  <= rd_accept;			// one cycle after acceptance
			claim_q <= rd_accept & port_hit;
			if (accept && bus_req.write) begin
				if (hit_scratch) begin
					scratch_q <= bus_req.wdata;
				end
				if (hit_irq) begin
					irq <= bus_req.wdata[0];	// 1 sets, 0 clears
				end
				// dipsw port ignores writes
			end
		end
	end

	always_ff @(posedge clk42m) begin
		if (rd_accept) begin
			rdata_q <= read_mux;
		end
	end

	assign bus_rsp = '{done: done_q, rdata_en: claim_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== logic/msx_slot.sv ====
/*
 * MSX slot bridge
 * turns host I/O cycles into internal bus requests, holds wait during
 * reads and returns read data and the interrupt to the slot
 */
`timescale 1ns/1ps
`default_nettype none

module msx_slot import cartridge_pkg::*; (
	input  wire         clk42m,
	input  wire         rst,
	// slot side
	input  wire         p_slot_ioreq_n,
	input  wire         p_slot_rd_n,
	input  wire         p_slot_wr_n,
	input  wire  [15:0] p_slot_address,		// upper byte unused on I/O
	input  wire         bus_data_t p_slot_wdata,
	output bus_data_t   p_slot_rdata,
	output logic        p_slot_data_dir,	// 1: cartridge drives data
	output logic        p_slot_wait,		// 1: host holds the cycle
	output logic        p_slot_int,			// 1: interrupt pending
	// from the device side
	input  wire         irq,
	// internal bus
	output bus_req_t    bus_req,
	output logic        bus_valid,
	input  wire         bus_ready,
	input  wire         bus_rsp_t bus_rsp
);

	slot_state_t state_q;
	logic        sync_ioreq_n;
	logic        sync_rd_n;
	logic        sync_wr_n;
	logic        read_start;
	logic        write_start;
	logic        armed_q;					// ioreq_n seen high since last cycle
	logic        take_cycle;				// start of a new host cycle

	// ------------------------------------------------------------
	// strobe synchronizer
	// ------------------------------------------------------------
	slot_input_sync u_slot_input_sync (
		.clk42m       ( clk42m         ),
		.rst          ( rst            ),
		.ioreq_n      ( p_slot_ioreq_n ),
		.rd_n         ( p_slot_rd_n    ),
		.wr_n         ( p_slot_wr_n    ),
		.sync_ioreq_n ( sync_ioreq_n   ),
		.sync_rd_n    ( sync_rd_n      ),
		.sync_wr_n    ( sync_wr_n      ),
		.read_start   ( read_start     ),
		.write_start  ( write_start    )
	);

	assign take_cycle = (state_q == IDLE) && (read_start || write_start) && armed_q;

	// ------------------------------------------------------------
	// cycle sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (rst) begin
			state_q         <= IDLE;
			bus_valid       <= 1'b0;
			p_slot_wait     <= 1'b0;
			p_slot_data_dir <= 1'b0;
			p_slot_int      <= 1'b0;
			armed_q         <= 1'b0;
		end else begin
			p_slot_int <= irq;				// registered onto the slot
			if (sync_ioreq_n) begin
				armed_q <= 1'b1;			// host left the last cycle
			end
			case (state_q)
				IDLE: begin
					if (take_cycle) begin
						bus_valid   <= 1'b1;
						p_slot_wait <= read_start;	// reads only
						armed_q     <= 1'b0;
						state_q     <= REQUEST;
					end
				end
				REQUEST: begin
					if (bus_ready) begin		// accepted this cycle
						bus_valid <= 1'b0;
						state_q   <= bus_req.write ? RELEASE : READ_WAIT;
					end
				end
				READ_WAIT: begin
					if (bus_rsp.done) begin
						p_slot_wait     <= 1'b0;
						p_slot_data_dir <= bus_rsp.rdata_en;	// only if claimed
						state_q         <= DRIVE;
					end
				end
				DRIVE: begin
					if (sync_rd_n) begin		// host finished the read
						p_slot_data_dir <= 1'b0;
						state_q         <= RELEASE;
					end
				end
				RELEASE: begin
					if (sync_rd_n && sync_wr_n) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// request and read data capture
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (take_cycle) begin
			bus_req.address <= p_slot_address[7:0];
			bus_req.write   <= ~read_start;	// read wins a tie
			bus_req.wdata   <= p_slot_wdata;
		end
		if (state_q == READ_WAIT && bus_rsp.done) begin
			p_slot_rdata <= bus_rsp.rdata;	// held while driving
		end
	end

endmodule

`default_nettype wire

// ==== logic/slot_input_sync.sv ====
/*
 * slot strobe synchronizer
 * brings ioreq_n, rd_n and wr_n into clk42m and flags the start of
 * a host read or write cycle with a one-cycle pulse
 */
`timescale 1ns/1ps
`default_nettype none

module slot_input_sync (
	input  wire  clk42m,
	input  wire  rst,
	input  wire  ioreq_n,					// async from host
	input  wire  rd_n,
	input  wire  wr_n,
	output logic sync_ioreq_n,				// synchronized levels
	output logic sync_rd_n,
	output logic sync_wr_n,
	output logic read_start,				// one pulse per read cycle
	output logic write_start				// one pulse per write cycle
);

	logic [2:0] meta_q;						// first stage {ioreq, rd, wr}
	logic [2:0] sync_q;						// second stage
	logic       rd_last_q;					// previous sync rd_n
	logic       wr_last_q;					// previous sync wr_n

	// ------------------------------------------------------------
	// two-flop sync and falling edge detect
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (rst) begin
			meta_q      <= 3'b111;			// strobes idle high
			sync_q      <= 3'b111;
			rd_last_q   <= 1'b1;
			wr_last_q   <= 1'b1;
			read_start  <= 1'b0;
			write_start <= 1'b0;
		end else begin
			meta_q      <= {ioreq_n, rd_n, wr_n};
			sync_q      <= meta_q;
			rd_last_q   <= sync_q[1];
			wr_last_q   <= sync_q[0];
			// edge only counts inside an I/O cycle
			read_start  <= rd_last_q & ~sync_q[1] & ~sync_q[2];
			write_start <= wr_last_q & ~sync_q[0] & ~sync_q[2];
		end
	end

	assign sync_ioreq_n = sync_q[2];
	assign sync_rd_n    = sync_q[1];
	assign sync_wr_n    = sync_q[0];

endmodule

`default_nettype wire

// ==== logic/cartridge_pkg.sv ====
/*
 * cartridge bus package
 * widths, bridge/controller bus structs and the slot bridge state encoding
 */
`default_nettype none

package cartridge_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int addr_w  = 8;				// I/O cycles decode the low byte only
	localparam int data_w  = 8;				// slot data bus
	localparam int dipsw_w = 5;				// board switches

	typedef logic [addr_w-1:0]  io_addr_t;		// I/O port number
	typedef logic [data_w-1:0]  bus_data_t;		// slot / bus data byte
	typedef logic [dipsw_w-1:0] dipsw_t;		// raw switch state

	// ------------------------------------------------------------
	// internal cartridge bus
	// ------------------------------------------------------------
	// bridge -> controller, held stable while bus_valid is high
	typedef struct packed {
		io_addr_t  address;				// port number
		logic      write;				// 1 write, 0 read
		bus_data_t wdata;				// host data, writes only
	} bus_req_t;

	// controller -> bridge, one pulse per accepted read
	typedef struct packed {
		logic      done;				// ends the read
		logic      rdata_en;			// port claimed
		bus_data_t rdata;				// read data
	} bus_rsp_t;

	// slot bridge sequencer
	typedef enum logic [2:0] {
		IDLE,							// wait for a host cycle
		REQUEST,						// bus_valid up, wait for ready
		READ_WAIT,						// hold the host, wait for done
		DRIVE,							// read data on the slot
		RELEASE							// wait for strobes to go away
	} slot_state_t;

endpackage

`default_nettype wire
